/* vlog.f */
logic/rv_isa_pkg.sv
logic/branch_pkg.sv
logic/branch_decode.sv
logic/gpr_file.sv
logic/bru.sv
logic/trap_csr.sv
logic/pc_unit.sv
logic/branch_top.sv
sim/branch_tb_clock.sv
sim/branch_assertions.sv
sim/branch_tb.sv

/* Makefile */
TOP = branch_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f vlog.f
	./obj_dir/V$(TOP) +verilator+error+limit+10000 | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* sim/branch_tb.sv */
// Stimulus only; the bound assertions check every result. Registers x16 to x31 stay zero.
`timescale 1ns/1ps
`default_nettype none

module branch_tb import rv_isa_pkg::*, branch_pkg::*; ();

  localparam int RANDOM_PER_FUNC = 8;
  localparam logic [ILEN-1:0] NOP_WORD   = 32'h0000_0013;
  localparam logic [ILEN-1:0] ECALL_WORD = 32'h0000_0073;
  localparam logic [ILEN-1:0] MRET_WORD  = 32'h3020_0073;

  logic            clk;
  logic            reset;
  logic            inst_valid;
  logic [ILEN-1:0] inst;
  gpr_wr_t         load;
  logic [XLEN-1:0] pc;
  redirect_t       redirect;
  logic [31:0]     lfsr;
  int unsigned     timeouts = 0;

  branch_tb_clock u_clock (
    .o_clk   (clk),
    .o_reset (reset)
  );

  branch_top i_branch_top (
    .i_clk        (clk),
    .i_reset      (reset),
    .i_inst_valid (inst_valid),
    .i_inst       (inst),
    .i_load       (load),
    .o_pc         (pc),
    .o_redirect   (redirect)
  );

  // Taps 32, 22, 2 and 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output logic [XLEN-1:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[XLEN-2:0], lfsr[0]};
    end
  endtask

  function automatic logic [ILEN-1:0] enc_branch(input logic [2:0] f3, input logic [4:0] rs1,
                                                 input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic logic [ILEN-1:0] enc_jal(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
  endfunction

  function automatic logic [ILEN-1:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1,
                                               input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, OP_JALR};
  endfunction

  // Called on a falling edge; holds the inputs for one full cycle.
  task automatic drive_cycle(input logic valid, input logic [ILEN-1:0] word, input gpr_wr_t req);
    inst_valid = valid;
    inst       = word;
    load       = req;
    @(negedge clk);
  endtask

  task automatic run_inst(input logic [ILEN-1:0] word);
    drive_cycle(1'b1, word, '0);
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) drive_cycle(1'b0, '0, '0);
  endtask

  task automatic load_reg(input logic [4:0] idx, input logic [XLEN-1:0] value);
    drive_cycle(1'b0, '0, '{valid: 1'b1, addr: idx, data: value});
  endtask

  // Equal, sign-boundary and mixed-sign pairs first, then random registers and offsets.
  task automatic branch_round(input logic [2:0] f3);
    logic [XLEN-1:0] r;
    run_inst(enc_branch(f3, 5'd3, 5'd4, 13'h0010));
    run_inst(enc_branch(f3, 5'd5, 5'd6, 13'h1ff8));
    run_inst(enc_branch(f3, 5'd6, 5'd5, 13'h0020));
    run_inst(enc_branch(f3, 5'd7, 5'd8, 13'h00c4));
    run_inst(enc_branch(f3, 5'd8, 5'd7, 13'h1f00));
    for (int n = 0; n < RANDOM_PER_FUNC; n++) begin
      random_bits(23, r);
      run_inst(enc_branch(f3, r[4:0], r[9:5], {r[21:10], 1'b0}));
      if (r[22]) begin
        idle_cycles(1);
      end
    end
  endtask

  task automatic end_run();
    int unsigned failures;
    failures = i_branch_top.u_assertions.fail_count;
    $display("Summary: %0d assertion failures, %0d timeouts", failures, timeouts);
    if (failures + timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  endtask

  initial begin : stimulus
    logic [XLEN-1:0] value;
    logic [XLEN-1:0] prev;
    lfsr       = 32'h4160_d201;
    inst_valid = 1'b0;
    inst       = '0;
    load       = '0;
    prev       = '0;
    @(negedge reset);
    @(negedge clk);
    idle_cycles(2);

    for (int k = 1; k < 16; k++) begin
      random_bits(XLEN, value);
      case (k)
        4:       value = prev;
        5:       value = {1'b1, {(XLEN-1){1'b0}}};
        6:       value = {1'b0, {(XLEN-1){1'b1}}};
        7:       value = '1;
        8:       value = XLEN'(1);
        default: value = value;
      endcase
      prev = value;
      load_reg(5'(k), value);
    end

    run_inst(NOP_WORD);
    idle_cycles(3);

    branch_round(F3_BEQ);
    branch_round(F3_BNE);
    branch_round(F3_BLT);
    branch_round(F3_BGE);
    branch_round(F3_BLTU);
    branch_round(F3_BGEU);

    // Link values are read back by the next instructions, and x0 must stay zero.
    run_inst(enc_jal(5'd10, 21'h00_0400));
    run_inst(enc_branch(F3_BEQ, 5'd10, 5'd3, 13'h0008));
    run_inst(enc_jalr(5'd0, 5'd10, 12'h010));
    run_inst(enc_jal(5'd0, 21'h1f_fff0));
    run_inst(enc_jalr(5'd11, 5'd0, 12'h7f0));
    idle_cycles(1);
    run_inst(enc_jalr(5'd1, 5'd11, 12'hffc));

    run_inst(ECALL_WORD);
    idle_cycles(1);
    run_inst(NOP_WORD);
    run_inst(enc_branch(F3_BNE, 5'd7, 5'd8, 13'h0040));
    run_inst(MRET_WORD);

    // Loads that collide with a link write are lost, whatever their address.
    drive_cycle(1'b1, enc_jal(5'd12, 21'h00_0100),
                '{valid: 1'b1, addr: 5'd12, data: 64'hdead_beef_0bad_f00d});
    run_inst(enc_jalr(5'd0, 5'd12, 12'h000));
    drive_cycle(1'b1, enc_jal(5'd0, 21'h00_0020), '{valid: 1'b1, addr: 5'd13, data: '1});
    run_inst(enc_branch(F3_BEQ, 5'd13, 5'd7, 13'h0100));
    run_inst(enc_branch(F3_BLTU, 5'd13, 5'd7, 13'h0200));

    idle_cycles(4);
    end_run();
  end

  initial begin : watchdog
    int unsigned limit_cycles;
    limit_cycles = 2 * (50 + 6 * (5 + 2 * RANDOM_PER_FUNC));
    repeat (limit_cycles) @(posedge clk);
    timeouts = 1;
    $display("Timeout: the stimulus was still running after %0d cycles", limit_cycles);
    end_run();
  end

endmodule

`default_nettype wire

/* sim/branch_assertions.sv */
// Shadow model sees only the top-level ports; JALR and SYSTEM words are expected with funct3 0.
`timescale 1ns/1ps
`default_nettype none

module branch_assertions import rv_isa_pkg::*, branch_pkg::*; (
  input logic            i_clk,
  input logic            i_reset,
  input logic            i_inst_valid,
  input logic [ILEN-1:0] i_inst,
  input gpr_wr_t         i_load,
  input logic [XLEN-1:0] o_pc,
  input redirect_t       o_redirect
);

  logic [XLEN-1:0] shadow_regs [NUM_GPR];
  logic [XLEN-1:0] exp_pc;
  logic [XLEN-1:0] exp_mepc;
  logic            exp_taken;
  logic            link_req;
  logic            ecall_req;
  logic [XLEN:0]   next_flow;
  int unsigned     fail_count = 0;

  // Returns the taken flag above the next PC, worked out from the ISA rules.
  function automatic logic [XLEN:0] resolve(input logic [ILEN-1:0] inst,
                                            input logic [XLEN-1:0] pc,
                                            input logic [XLEN-1:0] a,
                                            input logic [XLEN-1:0] b,
                                            input logic [XLEN-1:0] epc);
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] imm_i;
    logic            hit;
    imm_b = XLEN'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
    imm_j = XLEN'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
    imm_i = XLEN'($signed(inst[31:20]));
    hit   = 1'b0;
    if (inst[6:0] == OP_BRANCH) begin
      case (inst[14:12])
        3'b000:  hit = (a == b);
        3'b001:  hit = (a != b);
        3'b100:  hit = ($signed(a) < $signed(b));
        3'b101:  hit = ($signed(a) >= $signed(b));
        3'b110:  hit = (a < b);
        3'b111:  hit = (a >= b);
        default: hit = 1'b0;
      endcase
      return hit ? {1'b1, pc + imm_b} : {1'b0, pc + XLEN'(4)};
    end
    if (inst[6:0] == OP_JAL) return {1'b1, pc + imm_j};
    if ((inst[6:0] == OP_JALR) && (inst[14:12] == 3'b000)) return {1'b1, a + imm_i};
    if ((inst[6:0] == OP_SYSTEM) && (inst[14:12] == 3'b000)) begin
      if (inst[31:20] == FUNCT12_ECALL) return {1'b1, MTVEC_ADDR};
      if (inst[31:20] == FUNCT12_MRET) return {1'b1, epc};
    end
    return {1'b0, pc + XLEN'(4)};
  endfunction

  assign link_req  = i_inst_valid && ((i_inst[6:0] == OP_JAL) ||
                     ((i_inst[6:0] == OP_JALR) && (i_inst[14:12] == 3'b000)));
  assign ecall_req = i_inst_valid && (i_inst[6:0] == OP_SYSTEM) &&
                     (i_inst[14:12] == 3'b000) && (i_inst[31:20] == FUNCT12_ECALL);
  assign next_flow = resolve(i_inst, exp_pc, shadow_regs[i_inst[19:15]],
                             shadow_regs[i_inst[24:20]], exp_mepc);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      exp_pc    <= RESET_PC;
      exp_taken <= 1'b0;
      exp_mepc  <= '0;
      for (int i = 0; i < NUM_GPR; i++) begin
        shadow_regs[i] <= '0;
      end
    end else begin
      exp_taken <= i_inst_valid & next_flow[XLEN];
      if (i_inst_valid) begin
        exp_pc <= next_flow[XLEN-1:0];
      end
      if (ecall_req) begin
        exp_mepc <= exp_pc;
      end
      // The link writer owns the port, so a load in the same cycle is lost.
      if (link_req) begin
        if (i_inst[11:7] != '0) begin
          shadow_regs[i_inst[11:7]] <= exp_pc + XLEN'(4);
        end
      end else if (i_load.valid && (i_load.addr != '0)) begin
        shadow_regs[i_load.addr] <= i_load.data;
      end
    end
  end

  pc_matches: assert property (@(posedge i_clk) disable iff (i_reset) o_pc == exp_pc)
    else begin
      fail_count++;
      $error("CHECK FAILED at %0t: o_pc is %h, model expects %h", $time, o_pc, exp_pc);
    end

  taken_matches: assert property (@(posedge i_clk) disable iff (i_reset)
                                  o_redirect.taken == exp_taken)
    else begin
      fail_count++;
      $error("CHECK FAILED at %0t: o_redirect.taken is %b, model expects %b",
             $time, o_redirect.taken, exp_taken);
    end

  target_matches: assert property (@(posedge i_clk) disable iff (i_reset)
                                   exp_taken |-> o_redirect.target == exp_pc)
    else begin
      fail_count++;
      $error("CHECK FAILED at %0t: o_redirect.target is %h, model expects %h",
             $time, o_redirect.target, exp_pc);
    end

  pc_holds_idle: assert property (@(posedge i_clk) disable iff (i_reset)
                                  !$past(i_inst_valid) |-> $stable(o_pc))
    else begin
      fail_count++;
      $error("CHECK FAILED at %0t: o_pc moved from %h to %h with no instruction strobed",
             $time, $past(o_pc), o_pc);
    end

  reset_state: assert property (@(posedge i_clk)
                                $fell(i_reset) |-> (o_pc == RESET_PC) && !o_redirect.taken)
    else begin
      fail_count++;
      $error("CHECK FAILED at %0t: after reset o_pc is %h and o_redirect.taken is %b",
             $time, o_pc, o_redirect.taken);
    end

endmodule

bind branch_top branch_assertions u_assertions (
  .i_clk        (i_clk),
  .i_reset      (i_reset),
  .i_inst_valid (i_inst_valid),
  .i_inst       (i_inst),
  .i_load       (i_load),
  .o_pc         (o_pc),
  .o_redirect   (o_redirect)
);

`default_nettype wire

/* sim/branch_tb_clock.sv */
// Clock period is 100 ns; reset is held for three rising edges and released on a falling edge.
`timescale 1ns/1ps
`default_nettype none

module branch_tb_clock (
  output logic o_clk,
  output logic o_reset
);

  initial begin
    o_clk = 1'b0;
    forever begin
      #50 o_clk = ~o_clk;
    end
  end

  initial begin
    o_reset = 1'b1;
    repeat (3) @(posedge o_clk);
    @(negedge o_clk);
    o_reset = 1'b0;
  end

endmodule

`default_nettype wire

/* logic/branch_top.sv */
// Branch slice of an RV64 execute stage; no back-pressure, one instruction per strobe.
`timescale 1ns/1ps
`default_nettype none

module branch_top import rv_isa_pkg::*, branch_pkg::*; (
  input  logic            i_clk,
  input  logic            i_reset,
  input  logic            i_inst_valid,
  input  logic [ILEN-1:0] i_inst,
  input  gpr_wr_t         i_load,
  output logic [XLEN-1:0] o_pc,
  output redirect_t       o_redirect
);

  br_ctrl_t        ctrl;
  logic [XLEN-1:0] rs1_data;
  logic [XLEN-1:0] rs2_data;
  logic            ep_sel;
  logic [XLEN-1:0] epnpc;
  redirect_t       br_result;
  gpr_wr_t         link;

  branch_decode u_decode (
    .i_inst       (i_inst),
    .i_inst_valid (i_inst_valid),
    .o_ctrl       (ctrl)
  );

  gpr_file u_gpr (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .i_rs1      (ctrl.rs1),
    .i_rs2      (ctrl.rs2),
    .i_link     (link),
    .i_load     (i_load),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  trap_csr u_trap (
    .i_clk    (i_clk),
    .i_reset  (i_reset),
    .i_ctrl   (ctrl),
    .i_pc     (o_pc),
    .o_ep_sel (ep_sel),
    .o_epnpc  (epnpc)
  );

  bru u_bru (
    .i_ctrl     (ctrl),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .i_pc       (o_pc),
    .i_ep_sel   (ep_sel),
    .i_epnpc    (epnpc),
    .o_redirect (br_result)
  );

  pc_unit u_pc (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_inst_valid (i_inst_valid),
    .i_ctrl       (ctrl),
    .i_redirect   (br_result),
    .o_pc         (o_pc),
    .o_link       (link),
    .o_redirect   (o_redirect)
  );

endmodule

`default_nettype wire

/* logic/pc_unit.sv */
// PC moves only on a strobe; o_redirect is a one-cycle pulse registered from the strobe cycle.
`timescale 1ns/1ps
`default_nettype none

module pc_unit import rv_isa_pkg::*, branch_pkg::*; (
  input  logic            i_clk,
  input  logic            i_reset,
  input  logic            i_inst_valid,
  input  br_ctrl_t        i_ctrl,
  input  redirect_t       i_redirect,
  output logic [XLEN-1:0] o_pc,
  output gpr_wr_t         o_link,
  output redirect_t       o_redirect
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_plus4;
  logic            taken_q;
  logic [XLEN-1:0] target_q;

  assign pc_plus4 = pc_q + XLEN'(4);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      pc_q    <= RESET_PC;
      taken_q <= 1'b0;
    end else begin
      taken_q <= i_inst_valid & i_redirect.taken;
      if (i_inst_valid) begin
        pc_q <= i_redirect.taken ? i_redirect.target : pc_plus4;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_inst_valid) begin
      target_q <= i_redirect.target;
    end
  end

  // The link value is written by the same edge that moves the PC.
  assign o_link.valid = i_ctrl.br_en && ((i_ctrl.func == BR_JAL) || (i_ctrl.func == BR_JALR));
  assign o_link.addr  = i_ctrl.rd;
  assign o_link.data  = pc_plus4;

  assign o_pc              = pc_q;
  assign o_redirect.taken  = taken_q;
  assign o_redirect.target = target_q;

endmodule

`default_nettype wire

/* logic/trap_csr.sv */
// Only mepc is kept; the trap vector is the constant MTVEC_ADDR and no cause is recorded.
`timescale 1ns/1ps
`default_nettype none

module trap_csr import rv_isa_pkg::*, branch_pkg::*; (
  input  logic            i_clk,
  input  logic            i_reset,
  input  br_ctrl_t        i_ctrl,
  input  logic [XLEN-1:0] i_pc,
  output logic            o_ep_sel,
  output logic [XLEN-1:0] o_epnpc
);

  logic [XLEN-1:0] mepc;

  // The ecall flag is already qualified by the strobe in the decoder.
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      mepc <= '0;
    end else if (i_ctrl.ecall) begin
      mepc <= i_pc;
    end
  end

  assign o_ep_sel = i_ctrl.ecall | i_ctrl.mret;
  assign o_epnpc  = i_ctrl.ecall ? MTVEC_ADDR : mepc;

endmodule

`default_nettype wire

/* logic/bru.sv */
// Purely combinational; the JALR target keeps bit 0 as computed, no alignment check.
`timescale 1ns/1ps
`default_nettype none

module bru import rv_isa_pkg::*, branch_pkg::*; (
  input  br_ctrl_t        i_ctrl,
  input  logic [XLEN-1:0] i_rs1_data,
  input  logic [XLEN-1:0] i_rs2_data,
  input  logic [XLEN-1:0] i_pc,
  input  logic            i_ep_sel,
  input  logic [XLEN-1:0] i_epnpc,
  output redirect_t       o_redirect
);

  logic [XLEN-1:0] diff;
  logic            borrow;
  logic            overflow;
  logic            zero;
  logic            signed_less;
  logic            unsigned_less;
  logic            cond;
  logic            br_hit;
  logic [XLEN-1:0] base;
  logic [XLEN-1:0] offset;

  // One subtractor serves every compare.
  assign {borrow, diff} = {1'b0, i_rs1_data} - {1'b0, i_rs2_data};

  assign overflow = (i_rs1_data[XLEN-1] != i_rs2_data[XLEN-1]) &&
                    (diff[XLEN-1] != i_rs1_data[XLEN-1]);

  assign signed_less   = diff[XLEN-1] ^ overflow;
  assign unsigned_less = borrow;
  assign zero          = ~|diff;

  always_comb begin
    case (i_ctrl.func)
      BR_JAL:  cond = 1'b1;
      BR_JALR: cond = 1'b1;
      BR_BEQ:  cond = zero;
      BR_BNE:  cond = ~zero;
      BR_BLT:  cond = signed_less;
      BR_BGE:  cond = ~signed_less;
      BR_BLTU: cond = unsigned_less;
      BR_BGEU: cond = ~unsigned_less;
      default: cond = 1'b0;
    endcase
  end

  assign br_hit = i_ctrl.br_en & cond;

  // JALR is the only case that offsets from a register rather than the PC.
  assign base   = (i_ctrl.br_en && (i_ctrl.func == BR_JALR)) ? i_rs1_data : i_pc;
  assign offset = br_hit ? i_ctrl.imm : XLEN'(4);

  assign o_redirect.taken  = br_hit | i_ep_sel;
  assign o_redirect.target = i_ep_sel ? i_epnpc : base + offset;

endmodule

`default_nettype wire

/* logic/gpr_file.sv */
// One write port shared by link and load; a load that collides with a link write is dropped.
`timescale 1ns/1ps
`default_nettype none

module gpr_file import rv_isa_pkg::*, branch_pkg::*; (
  input  logic              i_clk,
  input  logic              i_reset,
  input  logic [REG_AW-1:0] i_rs1,
  input  logic [REG_AW-1:0] i_rs2,
  input  gpr_wr_t           i_link,
  input  gpr_wr_t           i_load,
  output logic [XLEN-1:0]   o_rs1_data,
  output logic [XLEN-1:0]   o_rs2_data
);

  logic [XLEN-1:0] regs [NUM_GPR];
  gpr_wr_t         wr_grant;

  // The link writer always owns the port when it asks.
  assign wr_grant = i_link.valid ? i_link : i_load;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int i = 0; i < NUM_GPR; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_grant.valid && (wr_grant.addr != '0)) begin
      regs[wr_grant.addr] <= wr_grant.data;
    end
  end

  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

/* logic/branch_decode.sv */
// Decodes only branches, JAL, JALR, ECALL and MRET; all other words yield no flags.
`timescale 1ns/1ps
`default_nettype none

module branch_decode import rv_isa_pkg::*, branch_pkg::*; (
  input  logic [ILEN-1:0] i_inst,
  input  logic            i_inst_valid,
  output br_ctrl_t        o_ctrl
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [11:0]     funct12;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_i;

  assign opcode  = i_inst[6:0];
  assign funct3  = i_inst[14:12];
  assign funct12 = i_inst[31:20];

  assign imm_b = {{(XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_j = {{(XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};
  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};

  always_comb begin
    o_ctrl      = '0;
    o_ctrl.rs1  = i_inst[19:15];
    o_ctrl.rs2  = i_inst[24:20];
    o_ctrl.rd   = i_inst[11:7];
    o_ctrl.func = BR_JAL;
    o_ctrl.imm  = imm_b;
    if (i_inst_valid) begin
      case (opcode)
        OP_BRANCH: begin
          o_ctrl.br_en = 1'b1;
          case (funct3)
            F3_BEQ:  o_ctrl.func = BR_BEQ;
            F3_BNE:  o_ctrl.func = BR_BNE;
            F3_BLT:  o_ctrl.func = BR_BLT;
            F3_BGE:  o_ctrl.func = BR_BGE;
            F3_BLTU: o_ctrl.func = BR_BLTU;
            F3_BGEU: o_ctrl.func = BR_BGEU;
            // Codes 010 and 011 are reserved for branches.
            default: o_ctrl.br_en = 1'b0;
          endcase
        end
        OP_JAL: begin
          o_ctrl.br_en = 1'b1;
          o_ctrl.func  = BR_JAL;
          o_ctrl.imm   = imm_j;
        end
        OP_JALR: begin
          o_ctrl.br_en = (funct3 == F3_JALR);
          o_ctrl.func  = BR_JALR;
          o_ctrl.imm   = imm_i;
        end
        OP_SYSTEM: begin
          o_ctrl.ecall = (funct3 == F3_PRIV) && (funct12 == FUNCT12_ECALL);
          o_ctrl.mret  = (funct3 == F3_PRIV) && (funct12 == FUNCT12_MRET);
        end
        default: begin
          o_ctrl.br_en = 1'b0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/branch_pkg.sv */
// Control-flow types for the branch slice; br_func_e codes are fixed and shared with the decoder.
`default_nettype none

package branch_pkg;
  import rv_isa_pkg::*;

  // Jumps sit at 000 and 001 so that compares occupy the upper six codes.
  typedef enum logic [2:0] {
    BR_JAL  = 3'b000,
    BR_JALR = 3'b001,
    BR_BEQ  = 3'b010,
    BR_BNE  = 3'b011,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_func_e;

  typedef struct packed {
    logic              br_en;
    logic              ecall;
    logic              mret;
    br_func_e          func;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [REG_AW-1:0] rd;
    logic [XLEN-1:0]   imm;
  } br_ctrl_t;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic              valid;
    logic [REG_AW-1:0] addr;
    logic [XLEN-1:0]   data;
  } gpr_wr_t;

endpackage

`default_nettype wire

/* logic/rv_isa_pkg.sv */
// RV64 control-flow subset only; reset PC and trap vector are fixed addresses, no CSR file.
`default_nettype none

package rv_isa_pkg;

  localparam int XLEN    = 64;
  localparam int ILEN    = 32;
  localparam int REG_AW  = 5;
  localparam int NUM_GPR = 32;

  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;
  localparam logic [2:0] F3_JALR = 3'b000;
  localparam logic [2:0] F3_PRIV = 3'b000;

  localparam logic [11:0] FUNCT12_ECALL = 12'h000;
  localparam logic [11:0] FUNCT12_MRET  = 12'h302;

  localparam logic [XLEN-1:0] RESET_PC   = 64'h0000_0000_8000_0000;
  localparam logic [XLEN-1:0] MTVEC_ADDR = 64'h0000_0000_8000_0100;

endpackage

`default_nettype wire
